//--- hw/fifo_data_pkg.sv
`default_nettype none

package fifo_data_pkg;

   //##########################################################
   //# data path
   //##########################################################

   // payload width of one fifo entry
   localparam int DATA_W = 32;

   // one word as it travels from the write port to the read port
   typedef logic [DATA_W-1:0] word_t;  // ram cell, in_data, out_data

   // control state and counters are in fifo_ctrl_pkg

endpackage

`default_nettype wire

//--- hw/fifo_ctrl_pkg.sv
`default_nettype none

package fifo_ctrl_pkg;

   //##########################################################
   //# read side fsm
   //##########################################################

   typedef enum logic [1:0]
   {
      EMPTY = 2'd0,  // nothing in output register
      FETCH = 2'd1,  // ram read in flight
      HOLD  = 2'd2   // output register valid
   } rd_state_t;

   //##########################################################
   //# write throttle
   //##########################################################

   localparam int WAIT_W = 8;  // free running, wraps
   typedef logic [WAIT_W-1:0] wait_cnt_t;

endpackage

`default_nettype wire

//--- hw/fifo_ram_if.sv
`default_nettype none

// storage array ports, write side on wr_clk and read side on rd_clk
interface fifo_ram_if
  #(parameter int DEPTH = 16);

   localparam int RAM_AW = $clog2(DEPTH);  // no wrap bit here

   // write port
   logic                  wr_en;
   logic [RAM_AW-1:0]     wr_addr;
   fifo_data_pkg::word_t  wr_data;

   // read port
   logic                  rd_en;
   logic [RAM_AW-1:0]     rd_addr;
   fifo_data_pkg::word_t  rd_data;   // valid one rd_clk after rd_en

   // write controller
   modport wr  (output wr_en, wr_addr, wr_data);

   // read fsm
   modport rd  (output rd_en, rd_addr, input rd_data);

   // the array itself
   modport mem (input wr_en, wr_addr, wr_data, rd_en, rd_addr,
                output rd_data);

endinterface

`default_nettype wire

//--- hw/fifo_wait_timer.sv
`default_nettype none

module fifo_wait_timer
  #(parameter int WAIT_PERIOD = 0)   // 0 keeps the gate open
   (input  logic wr_clk,
    input  logic nreset,
    output logic wr_gate);   // high in open cycles

   // divisor kept nonzero even when throttling is off
   localparam fifo_ctrl_pkg::wait_cnt_t PERIOD =
      fifo_ctrl_pkg::wait_cnt_t'((WAIT_PERIOD == 0) ? 1 : WAIT_PERIOD);

   fifo_ctrl_pkg::wait_cnt_t wait_cnt;   // free running

   //##########################################################
   //# counter
   //##########################################################

   always_ff @(posedge wr_clk or negedge nreset)
   begin
      if (!nreset)
         wait_cnt <= '0;
      else
         wait_cnt <= wait_cnt + 1'b1;   // wraps at 256
   end

   // one open cycle per period
   assign wr_gate = (WAIT_PERIOD == 0) | ((wait_cnt % PERIOD) == '0);

endmodule

`default_nettype wire

//--- hw/fifo_ptr_sync.sv
`default_nettype none

module fifo_ptr_sync
  #(parameter int AW = 5)   // pointer width incl. wrap bit
   (input  logic          dst_clk,
    input  logic          nreset,
    input  logic [AW-1:0] ptr_gray,   // source domain, gray coded
    output logic [AW-1:0] ptr_bin);   // destination domain, binary

   logic [AW-1:0] sync_q1;   // may go metastable
   logic [AW-1:0] sync_q2;   // settled

   //##########################################################
   //# two flop retiming
   //##########################################################

   always_ff @(posedge dst_clk or negedge nreset)
   begin
      if (!nreset)
      begin
         sync_q1 <= '0;
         sync_q2 <= '0;
      end
      else
      begin
         sync_q1 <= ptr_gray;
         sync_q2 <= sync_q1;
      end
   end

   // gray to binary
   // each bit is xor of itself and all higher gray bits
   always_comb
   begin
      for (int i = 0; i < AW; i++)
         ptr_bin[i] = ^(sync_q2 >> i);
   end

endmodule

`default_nettype wire

//--- hw/fifo_dpram.sv
`default_nettype none

module fifo_dpram
  #(parameter int DEPTH = 16)
   (input  logic    wr_clk,
    input  logic    rd_clk,
    fifo_ram_if.mem ram);

   //##########################################################
   //# storage array
   //##########################################################

   fifo_data_pkg::word_t mem [DEPTH];

   // write side, same edge as handshake
   always_ff @(posedge wr_clk)
   begin
      if (ram.wr_en)
         mem[ram.wr_addr] <= ram.wr_data;
   end

   // registered read
   // data valid one rd_clk after rd_en
   always_ff @(posedge rd_clk)
   begin
      if (ram.rd_en)
         ram.rd_data <= mem[ram.rd_addr];  // holds between reads
   end

   // address width follows DEPTH through the interface

endmodule

`default_nettype wire

//--- hw/fifo_wr_ctrl.sv
`default_nettype none

module fifo_wr_ctrl
  #(parameter int DEPTH           = 16,
    parameter int PROG_FULL_LEVEL = 12)
   (input  logic                   wr_clk,
    input  logic                   nreset,
    input  logic                   in_valid,
    input  fifo_data_pkg::word_t   in_data,
    output logic                   in_ready,
    input  logic                   wr_gate,      // from wait timer
    input  logic [$clog2(DEPTH):0] rd_ptr_sync,  // binary, already retimed
    output logic [$clog2(DEPTH):0] wr_ptr_gray,
    output logic                   prog_full,
    fifo_ram_if.wr                 ram);

   localparam int AW = $clog2(DEPTH) + 1;

   typedef logic [AW-1:0] ptr_t;

   ptr_t wr_ptr;        // binary, with wrap bit
   ptr_t wr_ptr_next;
   ptr_t wr_occ;        // entries as seen from write side
   logic full;
   logic wr_active;     // low until first edge after reset
   logic wr_fire;

   //##########################################################
   //# occupancy and handshake
   //##########################################################

   // rd_ptr_sync lags, so this never underestimates
   assign wr_occ = wr_ptr - rd_ptr_sync;
   assign full   = (wr_occ == ptr_t'(DEPTH));

   // no dependence on in_valid
   assign in_ready = wr_active & wr_gate & ~full;
   assign wr_fire  = in_valid & in_ready;

   assign wr_ptr_next = wr_ptr + ptr_t'(wr_fire);

   // word lands in the array on the accepting edge
   assign ram.wr_en   = wr_fire;
   assign ram.wr_addr = wr_ptr[AW-2:0];   // drop wrap bit
   assign ram.wr_data = in_data;

   //##########################################################
   //# pointer and status registers
   //##########################################################

   always_ff @(posedge wr_clk or negedge nreset)
   begin
      if (!nreset)
      begin
         wr_active   <= 1'b0;
         wr_ptr      <= '0;
         wr_ptr_gray <= '0;
         prog_full   <= 1'b0;
      end
      else
      begin
         wr_active   <= 1'b1;
         wr_ptr      <= wr_ptr_next;
         wr_ptr_gray <= wr_ptr_next ^ (wr_ptr_next >> 1);  // one bit flips per step
         // one cycle behind occupancy
         prog_full   <= (wr_occ >= ptr_t'(PROG_FULL_LEVEL));
      end
   end

endmodule

`default_nettype wire

//--- hw/fifo_rd_fsm.sv
`default_nettype none

module fifo_rd_fsm
  #(parameter int DEPTH = 16)
   (input  logic                   rd_clk,
    input  logic                   nreset,
    input  logic [$clog2(DEPTH):0] wr_ptr_sync,  // binary, retimed
    output logic [$clog2(DEPTH):0] rd_ptr_gray,
    output logic                   out_valid,
    input  logic                   out_ready,
    output fifo_data_pkg::word_t   out_data,     // show ahead
    output logic [$clog2(DEPTH):0] rd_count,
    fifo_ram_if.rd                 ram);

   localparam int AW = $clog2(DEPTH) + 1;

   typedef logic [AW-1:0] ptr_t;

   fifo_ctrl_pkg::rd_state_t state;
   fifo_ctrl_pkg::rd_state_t state_next;

   ptr_t rd_ptr;        // next word to fetch
   ptr_t rd_ptr_next;
   logic avail;         // unfetched word in the array
   logic hold;
   logic fetch;

   //##########################################################
   //# fetch decision
   //##########################################################

   assign avail = (wr_ptr_sync != rd_ptr);
   assign hold  = (state == fifo_ctrl_pkg::HOLD);

   // refill from EMPTY, or refill on a pop
   assign fetch = avail & ((state == fifo_ctrl_pkg::EMPTY) | (hold & out_ready));

   assign ram.rd_en   = fetch;
   assign ram.rd_addr = rd_ptr[AW-2:0];

   // pointer moves on fetch, output reg is one extra slot
   assign rd_ptr_next = rd_ptr + ptr_t'(fetch);

   assign out_valid = hold;

   //##########################################################
   //# state machine
   //##########################################################

   always_comb
   begin
      state_next = state;
      case (state)
         fifo_ctrl_pkg::EMPTY:
         begin
            if (fetch)
               state_next = fifo_ctrl_pkg::FETCH;
         end
         fifo_ctrl_pkg::FETCH:
            state_next = fifo_ctrl_pkg::HOLD;   // rd_data ready now
         fifo_ctrl_pkg::HOLD:
         begin
            if (out_ready)   // popped
               state_next = fetch ? fifo_ctrl_pkg::FETCH : fifo_ctrl_pkg::EMPTY;
         end
         default:
            state_next = fifo_ctrl_pkg::EMPTY;
      endcase
   end

   always_ff @(posedge rd_clk or negedge nreset)
   begin
      if (!nreset)
      begin
         state       <= fifo_ctrl_pkg::EMPTY;
         rd_ptr      <= '0;
         rd_ptr_gray <= '0;
         rd_count    <= '0;
      end
      else
      begin
         state       <= state_next;
         rd_ptr      <= rd_ptr_next;
         rd_ptr_gray <= rd_ptr_next ^ (rd_ptr_next >> 1);
         // array words plus the held one
         rd_count    <= (wr_ptr_sync - rd_ptr) + {{(AW-1){1'b0}}, hold};
      end
   end

   //##########################################################
   //# output register
   //##########################################################

   // only loads leaving FETCH, stable through HOLD
   always_ff @(posedge rd_clk)
   begin
      if (state == fifo_ctrl_pkg::FETCH)
         out_data <= ram.rd_data;
   end

endmodule

`default_nettype wire

//--- hw/fifo_async_top.sv
`default_nettype none

module fifo_async_top
  #(parameter int DEPTH           = 16,  // power of two
    parameter int PROG_FULL_LEVEL = 12,  // write side occupancy threshold
    parameter int WAIT_PERIOD     = 0)   // 0 means no throttling
   (input  logic                  wr_clk,
    input  logic                  rd_clk,
    input  logic                  nreset,     // both domains
    // write port
    input  logic                  in_valid,
    input  fifo_data_pkg::word_t  in_data,
    output logic                  in_ready,
    output logic                  prog_full,
    // read port
    output logic                  out_valid,
    input  logic                  out_ready,
    output fifo_data_pkg::word_t  out_data,
    output logic [$clog2(DEPTH):0] rd_count);

   localparam int AW = $clog2(DEPTH) + 1;  // pointer plus wrap bit

   //##########################################################
   //# cross domain wires
   //##########################################################

   logic [AW-1:0] wr_ptr_gray;   // wr_clk domain
   logic [AW-1:0] wr_ptr_sync;   // seen on rd_clk
   logic [AW-1:0] rd_ptr_gray;   // rd_clk domain
   logic [AW-1:0] rd_ptr_sync;   // seen on wr_clk
   logic          wr_gate;       // throttle window

   fifo_ram_if #(.DEPTH(DEPTH)) i_ram_if ();

   //##########################################################
   //# write clock domain
   //##########################################################

   fifo_wait_timer #(.WAIT_PERIOD(WAIT_PERIOD)) i_wait_timer
     (.wr_clk (wr_clk),
      .nreset (nreset),
      .wr_gate(wr_gate));

   fifo_wr_ctrl #(.DEPTH(DEPTH), .PROG_FULL_LEVEL(PROG_FULL_LEVEL)) i_wr_ctrl
     (.wr_clk     (wr_clk),
      .nreset     (nreset),
      .in_valid   (in_valid),
      .in_data    (in_data),
      .in_ready   (in_ready),
      .wr_gate    (wr_gate),
      .rd_ptr_sync(rd_ptr_sync),
      .wr_ptr_gray(wr_ptr_gray),
      .prog_full  (prog_full),
      .ram        (i_ram_if.wr));

   // read pointer into write domain
   fifo_ptr_sync #(.AW(AW)) i_rd_ptr_sync
     (.dst_clk (wr_clk),
      .nreset  (nreset),
      .ptr_gray(rd_ptr_gray),
      .ptr_bin (rd_ptr_sync));

   //##########################################################
   //# storage and read clock domain
   //##########################################################

   fifo_dpram #(.DEPTH(DEPTH)) i_dpram
     (.wr_clk(wr_clk),
      .rd_clk(rd_clk),
      .ram   (i_ram_if.mem));

   // write pointer into read domain
   fifo_ptr_sync #(.AW(AW)) i_wr_ptr_sync
     (.dst_clk (rd_clk),
      .nreset  (nreset),
      .ptr_gray(wr_ptr_gray),
      .ptr_bin (wr_ptr_sync));

   fifo_rd_fsm #(.DEPTH(DEPTH)) i_rd_fsm
     (.rd_clk     (rd_clk),
      .nreset     (nreset),
      .wr_ptr_sync(wr_ptr_sync),
      .rd_ptr_gray(rd_ptr_gray),
      .out_valid  (out_valid),
      .out_ready  (out_ready),
      .out_data   (out_data),
      .rd_count   (rd_count),
      .ram        (i_ram_if.rd));

endmodule

`default_nettype wire

//--- tests/tb_fifo_checks.svh
`ifndef TB_FIFO_CHECKS_SVH
`define TB_FIFO_CHECKS_SVH

//##########################################################
//# random numbers
//##########################################################

// 32 bit xorshift, nonzero seed stays nonzero
function automatic logic [31:0] xorshift32(input logic [31:0] s);
   logic [31:0] x;
   x = s;
   x = x ^ (x << 13);
   x = x ^ (x >> 17);
   x = x ^ (x << 5);
   return x;
endfunction

//##########################################################
//# compare tasks
//##########################################################

task automatic check_word(input fifo_data_pkg::word_t got,
                          input fifo_data_pkg::word_t exp,
                          input string what);
   if (got !== exp)
   begin
      $display("CHECK FAILED at %0t: %s, got %h expected %h", $time, what, got, exp);
      end_run(1'b0);
   end
endtask

task automatic check_flag(input logic got, input logic exp, input string what);
   if (got !== exp)
   begin
      $display("CHECK FAILED at %0t: %s, got %b expected %b", $time, what, got, exp);
      end_run(1'b0);
   end
endtask

task automatic check_count(input count_t got, input count_t exp, input string what);
   if (got !== exp)
   begin
      $display("CHECK FAILED at %0t: %s, got %0d expected %0d", $time, what, got, exp);
      end_run(1'b0);
   end
endtask

//##########################################################
//# bounded waits
//##########################################################

// returns on the rd_clk edge that takes the last word
task automatic wait_for_pops(input int target, input int limit);
   int n;
   n = 0;
   while (n_popped < target)
   begin
      @(posedge rd_clk);
      n++;
      if (n > limit)
      begin
         $display("timeout: only %0d of %0d words left the read port", n_popped, target);
         $display("read fsm is in state %s", i_dut.i_rd_fsm.state.name());
         end_run(1'b0);
      end
   end
endtask

// returns on the wr_clk edge that accepts the last word
task automatic wait_for_accepts(input int target, input int limit);
   int n;
   n = 0;
   while (n_accepted < target)
   begin
      @(posedge wr_clk);
      n++;
      if (n > limit)
      begin
         $display("timeout: write port took %0d words, waiting for %0d", n_accepted, target);
         end_run(1'b0);
      end
   end
endtask

task automatic wr_negedges(input int n);
   repeat (n) @(negedge wr_clk);
endtask

task automatic rd_negedges(input int n);
   repeat (n) @(negedge rd_clk);
endtask

`endif

//--- tests/tb_fifo_async.sv
`default_nettype none

module tb_fifo_async;

   localparam int TB_DEPTH     = 16;
   localparam int TB_PROG_FULL = 12;
   localparam int TB_WAIT      = 4;
   localparam int CNT_W        = $clog2(TB_DEPTH) + 1;
   localparam int RANDOM_WORDS = 200;

   typedef logic [CNT_W-1:0] count_t;   // same as rd_count

   logic                 wr_clk;
   logic                 rd_clk;
   logic                 nreset;
   logic                 in_valid;
   fifo_data_pkg::word_t in_data;
   logic                 in_ready;
   logic                 prog_full;
   logic                 out_valid;
   logic                 out_ready;
   fifo_data_pkg::word_t out_data;
   count_t               rd_count;

   // stimulus control set on wr_clk falling edges
   int          wr_target;    // total accepted words to reach
   bit          wr_random;    // random in_valid when set
   int          rd_mode;      // 0 stall, 1 random, 2 always ready
   bit          fill_phase;
   int          fill_base;
   logic [31:0] wr_rng;
   logic [31:0] rd_rng;

   // scoreboard
   fifo_data_pkg::word_t written_q[$];   // every accepted word in order
   int                   n_accepted;
   int                   n_popped;
   bit                   held_valid;     // stalled at last sample
   fifo_data_pkg::word_t held_data;

   // write window model
   fifo_ctrl_pkg::wait_cnt_t wait_model;
   logic                     active_model;   // first edge after reset seen
   logic                     gate_open;

   fifo_async_top #(.DEPTH(TB_DEPTH), .PROG_FULL_LEVEL(TB_PROG_FULL),
                    .WAIT_PERIOD(TB_WAIT)) i_dut
     (.wr_clk   (wr_clk),
      .rd_clk   (rd_clk),
      .nreset   (nreset),
      .in_valid (in_valid),
      .in_data  (in_data),
      .in_ready (in_ready),
      .prog_full(prog_full),
      .out_valid(out_valid),
      .out_ready(out_ready),
      .out_data (out_data),
      .rd_count (rd_count));

   task automatic end_run(input bit ok);
      if (ok)
      begin
         $display("Test OK");
         $finish;
      end
      else
      begin
         $display("Test FAILED");
         $fatal(1, "stopped at first error");
      end
   endtask

   // n-th pop returns the n-th accepted write
   function automatic fifo_data_pkg::word_t expected_word(input int idx);
      return written_q[idx];
   endfunction

   `include "tb_fifo_checks.svh"

   task automatic check_drained();
      rd_negedges(1);   // pop edge leaves HOLD
      check_flag(out_valid, 1'b0, "out_valid after drain");
      rd_negedges(1);   // rd_count is one edge late
      check_count(rd_count, '0, "rd_count after drain");
   endtask

   always #50 wr_clk = ~wr_clk;
   always #35 rd_clk = ~rd_clk;

   //##########################################################
   //# window model and drivers
   //##########################################################

   always @(posedge wr_clk or negedge nreset)
   begin
      if (!nreset)
      begin
         wait_model   <= '0;
         active_model <= 1'b0;
      end
      else
      begin
         wait_model   <= wait_model + fifo_ctrl_pkg::wait_cnt_t'(1);   // wraps
         active_model <= 1'b1;
      end
   end

   assign gate_open = active_model && ((wait_model % TB_WAIT) == 0);

   always @(posedge wr_clk)
   begin
      wr_rng = xorshift32(wr_rng);
      in_data  <= wr_rng;
      in_valid <= (n_accepted < wr_target) && (!wr_random || wr_rng[7]);
   end

   always @(posedge rd_clk)
   begin
      rd_rng = xorshift32(rd_rng);
      case (rd_mode)
         1:       out_ready <= rd_rng[3];
         2:       out_ready <= 1'b1;
         default: out_ready <= 1'b0;
      endcase
   end

   //##########################################################
   //# monitors sampled on falling edges
   //##########################################################

   always @(negedge wr_clk)
   begin
      if (nreset)
      begin
         if (!gate_open)
            check_flag(in_ready, 1'b0, "in_ready outside the write window");
         // prog_full lags one edge and one word may sit in the output reg
         if (fill_phase && (n_accepted - fill_base < TB_PROG_FULL))
            check_flag(prog_full, 1'b0, "prog_full below threshold");
         else if (fill_phase && (n_accepted - fill_base >= TB_PROG_FULL + 2))
            check_flag(prog_full, 1'b1, "prog_full above threshold");
         if (in_valid && in_ready)   // taken on the next edge
         begin
            written_q.push_back(in_data);
            n_accepted++;
         end
      end
   end

   always @(negedge rd_clk)
   begin
      if (nreset)
      begin
         if (held_valid)
         begin
            check_flag(out_valid, 1'b1, "out_valid dropped during stall");
            check_word(out_data, held_data, "out_data moved during stall");
         end
         if (out_valid && out_ready)
         begin
            if (n_popped >= written_q.size())
            begin
               $display("read port gave a word that was never written, at %0t", $time);
               end_run(1'b0);
            end
            else
            begin
               check_word(out_data, expected_word(n_popped), "popped word");
               n_popped++;
            end
         end
         held_valid = out_valid && !out_ready;
         held_data  = out_data;
      end
   end

   //##########################################################
   //# scenarios
   //##########################################################

   initial
   begin
      int i;
      wr_clk     = 1'b0;
      rd_clk     = 1'b0;
      nreset     = 1'b0;
      in_valid   = 1'b0;
      in_data    = '0;
      out_ready  = 1'b0;
      wr_target  = 0;
      wr_random  = 1'b0;
      rd_mode    = 0;
      fill_phase = 1'b0;
      fill_base  = 0;
      wr_rng     = 32'd81;
      rd_rng     = xorshift32(32'd81);   // second stream off the same seed
      n_accepted = 0;
      n_popped   = 0;
      held_valid = 1'b0;
      held_data  = '0;

      repeat (10) @(posedge wr_clk);
      nreset <= 1'b1;

      // quiet fifo so in_ready follows the window exactly
      for (i = 0; i < 12; i++)
      begin
         @(negedge wr_clk);
         check_flag(in_ready, gate_open, "in_ready window after reset");
         check_flag(prog_full, 1'b0, "prog_full after reset");
      end
      for (i = 0; i < 4; i++)
      begin
         @(negedge rd_clk);
         check_flag(out_valid, 1'b0, "out_valid after reset");
         check_count(rd_count, '0, "rd_count after reset");
      end

      // random traffic both sides
      @(negedge wr_clk);
      wr_random = 1'b1;
      wr_target = RANDOM_WORDS;
      rd_mode   = 1;
      wait_for_pops(RANDOM_WORDS, 40000);
      check_drained();

      // fill with the reader stalled
      wr_negedges(4);   // read pointer settles on the write side
      fill_base  = n_accepted;
      fill_phase = 1'b1;
      rd_mode    = 0;
      wr_random  = 1'b0;
      wr_target  = n_accepted + 40;
      wait_for_accepts(fill_base + TB_DEPTH + 1, 2000);
      for (i = 0; i < 40; i++)
      begin
         @(negedge wr_clk);
         check_flag(in_ready, 1'b0, "in_ready while full");
      end
      check_flag(prog_full, 1'b1, "prog_full when full");
      rd_negedges(1);
      check_flag(out_valid, 1'b1, "out_valid when full");
      check_count(rd_count, count_t'(TB_DEPTH + 1), "rd_count when full");

      // drain everything
      @(negedge wr_clk);
      fill_phase = 1'b0;
      wr_target  = n_accepted;
      rd_mode    = 2;
      wait_for_pops(n_accepted, 2000);
      check_drained();

      end_run(1'b1);
   end

endmodule

`default_nettype wire

//--- flist.f
+incdir+tests
hw/fifo_data_pkg.sv
hw/fifo_ctrl_pkg.sv
hw/fifo_ram_if.sv
hw/fifo_wait_timer.sv
hw/fifo_ptr_sync.sv
hw/fifo_dpram.sv
hw/fifo_wr_ctrl.sv
hw/fifo_rd_fsm.sv
hw/fifo_async_top.sv
tests/tb_fifo_async.sv

//--- run.sh
#!/bin/sh
# verilator build and run of the dual clock fifo testbench
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal \
   -f flist.f \
   --top-module tb_fifo_async \
   -o tb_fifo_async

# the log holds the verdict
./obj_dir/tb_fifo_async > sim.log 2>&1 || true
cat sim.log

if grep -q "Test FAILED" sim.log; then
   echo "simulation failed"
   exit 1
fi
if ! grep -q "Test OK" sim.log; then
   echo "simulation ended without a verdict"
   exit 1
fi
echo "simulation passed"
